//--- bench/instFetchBench.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module instFetchBench
	import icachePkg::*;
();

	localparam int numFetches = 200;
	localparam int watchLimit = 2 * numFetches * 40 * 8;	// ns, two fetches per pc

	logic		clock;
	logic		reset;
	pcAddr		pc;
	fetchWindow	fetchWord;
	stepLen		fetchStep;
	memStatus	fetchStatus;
	pcAddr		memAddr;
	memOpcode	memOpm;
	tileData	memData;
	memStatus	memOk;
	fillCount	fills;

	integer		seed = 32'h20ae_f9e7;
	int			errorCount = 0;
	tileData	tileMem [64];	// backing store, aliased every 1 KB
	pcAddr		pcList [256];
	tileAddr	modelTag [16];
	logic		modelValid [16];
	fillCount	fillTally = '0;

	instFetchCache DUT
	(
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.fetchWord(fetchWord),
		.fetchStep(fetchStep),
		.fetchStatus(fetchStatus),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memData(memData),
		.memOk(memOk),
		.fills(fills)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic abortRun();
		errorCount++;
		$display("Regression failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic reportProblem(input string what);
		$display("%s", what);
		abortRun();
	endtask

	task automatic checkWindow(input fetchWindow got, input fetchWindow want);
		if (got !== want)
		begin
			$display("CHECK FAILED fetchWord got %h expected %h", got, want);
			abortRun();
		end
	endtask

	task automatic checkStep(input stepLen got, input stepLen want);
		if (got !== want)
		begin
			$display("CHECK FAILED fetchStep got %h expected %h", got, want);
			abortRun();
		end
	endtask

	task automatic checkStatus(input memStatus got, input memStatus want);
		if (got !== want)
		begin
			$display("CHECK FAILED fetchStatus got %h expected %h", got, want);
			abortRun();
		end
	endtask

	task automatic checkFills(input fillCount got, input fillCount want);
		if (got !== want)
		begin
			$display("CHECK FAILED fills got %h expected %h", got, want);
			abortRun();
		end
	endtask

	task automatic checkAddr(input pcAddr got, input pcAddr want);
		if (got !== want)
		begin
			$display("CHECK FAILED memAddr got %h expected %h", got, want);
			abortRun();
		end
	endtask

	task automatic checkOpcode(input memOpcode got, input memOpcode want);
		if (got !== want)
		begin
			$display("CHECK FAILED memOpm got %h expected %h", got, want);
			abortRun();
		end
	endtask

	function automatic tileData randomTile();
		tileData t;
		logic [31:0] r;
		t = '0;
		for (int w = 0; w < 8; w++)
		begin
			r = $random(seed);
			t = {r[15:0], t[127:16]};	// first draw lands in word 0
		end
		return t;
	endfunction

	function automatic tileAddr lowerTile(input pcAddr a);
		return a[31:4];
	endfunction

	function automatic tileAddr upperTile(input pcAddr a);
		if (a[3])
			return a[31:4] + 28'd1;
		return a[31:4];
	endfunction

	function automatic logic tileMissing(input tileAddr t);
		return !modelValid[t[3:0]] || (modelTag[t[3:0]] != t);
	endfunction

	// lower tile always wins when both are absent
	function automatic tileAddr neededTile(input pcAddr a);
		if (tileMissing(lowerTile(a)))
			return lowerTile(a);
		return upperTile(a);
	endfunction

	function automatic fetchWindow expectedWindow(input pcAddr a);
		fetchWindow win;
		pcAddr byteAddr;
		tileData shifted;
		win = '0;
		for (int k = 0; k < 4; k++)
		begin
			byteAddr = a + {29'd0, k[1:0], 1'b0};
			shifted = tileMem[byteAddr[9:4]] >> {byteAddr[3:1], 4'h0};
			win = {shifted[15:0], win[63:16]};	// word at pc ends up lowest
		end
		return win;
	endfunction

	function automatic stepLen expectedStep(input fetchWindow win);
		if (&win[15:13])
			return 2'd2;
		return 2'd1;
	endfunction

	// one tile transaction, entered on the edge that shows RD_TILE
	task automatic serveTile();
		pcAddr reqAddr;
		logic [31:0] r;
		int holdCycles;
		reqAddr = memAddr;
		if (reqAddr[3:0] != 4'h0)
			reportProblem("tile request address has nonzero low bits");
		if (!tileMissing(reqAddr[31:4]))
			reportProblem("tile request for a tile that is already resident");
		checkAddr(reqAddr, {neededTile(pc), 4'h0});
		r = $random(seed);
		holdCycles = int'(r % 32'd6);
		repeat (holdCycles)
		begin
			memOk <= `MEM_OK_HOLD;
			@(posedge clock);
			if ((memOpm != `MEM_OPM_RD_TILE) || (memAddr != reqAddr))
				reportProblem("tile request changed while memory held it off");
		end
		memOk <= `MEM_OK_OK;
		memData <= tileMem[reqAddr[9:4]];
		@(posedge clock);
		checkOpcode(memOpm, `MEM_OPM_RD_TILE);	// OK taken on this edge
		modelTag[reqAddr[7:4]] = reqAddr[31:4];
		modelValid[reqAddr[7:4]] = 1'b1;
		fillTally = fillTally + 16'd1;
		memOk <= `MEM_OK_HOLD;
		memData <= '0;
		r = $random(seed);
		holdCycles = 1 + int'(r % 32'd4);
		repeat (holdCycles)
		begin
			@(posedge clock);
			checkOpcode(memOpm, `MEM_OPM_READY);	// no new request until READY
		end
		memOk <= `MEM_OK_READY;
	endtask

	initial
	begin
		memOk <= `MEM_OK_READY;
		memData <= '0;
		forever
		begin
			@(posedge clock);
			if (!reset && (memOpm == `MEM_OPM_RD_TILE))
				serveTile();
		end
	end

	task automatic runFetch(input pcAddr addr, input logic mustHit);
		logic expectHit;
		fetchWindow wantWord;
		expectHit = !tileMissing(lowerTile(addr)) && !tileMissing(upperTile(addr));
		if (mustHit && !expectHit)
			reportProblem("refetch address is not resident in the model");
		wantWord = expectedWindow(addr);
		@(posedge clock);
		pc <= addr;
		@(posedge clock);	// lookup edge
		@(posedge clock);
		if (expectHit)
			checkStatus(fetchStatus, `MEM_OK_OK);
		while (fetchStatus != `MEM_OK_OK)
		begin
			checkStatus(fetchStatus, `MEM_OK_HOLD);
			@(posedge clock);
		end
		checkWindow(fetchWord, wantWord);
		checkStep(fetchStep, expectedStep(wantWord));
		if (expectHit)
		begin
			@(posedge clock);
			checkOpcode(memOpm, `MEM_OPM_READY);	// hit must not start a fill
		end
	endtask

	initial
	begin
		logic [31:0] r;
		for (int i = 0; i < 64; i++)
			tileMem[i[5:0]] = randomTile();
		for (int i = 0; i < numFetches; i++)
		begin
			r = $random(seed);
			pcList[i[7:0]] = {22'd16, r[9:1], 1'b0};	// 1 KB region at 0x4000
		end
		for (int s = 0; s < 16; s++)
			modelValid[s[3:0]] = 1'b0;
		reset <= 1'b1;
		pc <= pcList[0];
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		checkOpcode(memOpm, `MEM_OPM_READY);
		checkStatus(fetchStatus, `MEM_OK_HOLD);	// nothing valid yet
		for (int n = 0; n < numFetches; n++)
		begin
			runFetch(pcList[n[7:0]], 1'b0);
			runFetch(pcList[n[7:0]] ^ 32'h0000_0002, 1'b1);	// same tiles, new pc
		end
		repeat (4) @(posedge clock);
		checkFills(fills, fillTally);
		if (errorCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial
	begin
		#(watchLimit);
		reportProblem("watchdog expired before all fetches completed");
	end

endmodule

//--- compile.f
+incdir+hdl
hdl/icachePkg.sv
hdl/icacheBanks.sv
hdl/fetchAlign.sv
hdl/missController.sv
hdl/fillCounter.sv
hdl/instFetchCache.sv
bench/instFetchBench.sv

//--- hdl/fetchAlign.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module fetchAlign
	import icachePkg::*;
(
	input	pcAddr		lookPc,
	input	bankWord	bankDataA,
	input	bankWord	bankDataB,
	input	logic		missA,
	input	logic		missB,
	output	fetchWindow	fetchWord,
	output	stepLen		fetchStep,
	output	memStatus	fetchStatus
);

	tileData		line;
	logic [15:0]	firstWord;

	always_comb
	begin
		// straddling window: odd half of this tile, then even half of the next
		if (lookPc[3])
			line = {bankDataA, bankDataB};
		else
			line = {bankDataB, bankDataA};
	end

	always_comb
	begin
		case (lookPc[2:1])
			2'd0:		fetchWord = line[63:0];
			2'd1:		fetchWord = line[79:16];
			2'd2:		fetchWord = line[95:32];
			default:	fetchWord = line[111:48];
		endcase
	end

	assign firstWord = fetchWord[15:0];

	// top three bits set marks a 32-bit op
	always_comb
	begin
		if (firstWord[15:13] == 3'b111)
			fetchStep = 2'd2;
		else
			fetchStep = 2'd1;
	end

	assign fetchStatus = (missA || missB) ? `MEM_OK_HOLD : `MEM_OK_OK;

endmodule

//--- hdl/fillCounter.sv
`timescale 1ns/1ps

module fillCounter
	import icachePkg::*;
(
	input	logic		clock,
	input	logic		reset,
	input	logic		fillStrobe,
	output	fillCount	fills
);

	logic	atMax;

	assign atMax = (fills == '1);	// sticks at all ones

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fills <= '0;
		end
		else if (fillStrobe && !atMax)
		begin
			fills <= fills + 16'd1;
		end
	end

endmodule

//--- hdl/icacheBanks.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icacheBanks
	import icachePkg::*;
(
	input	logic		clock,
	input	logic		reset,
	input	pcAddr		pc,
	input	logic		fillStrobe,
	input	tileAddr	fillTile,
	input	tileData	fillData,
	output	pcAddr		lookPc,
	output	bankWord	bankDataA,
	output	bankWord	bankDataB,
	output	tileAddr	reqTileA,
	output	tileAddr	reqTileB,
	output	logic		missA,
	output	logic		missB
);

	bankWord	evenMem [`ICACHE_SETS];	// low half of each tile
	bankWord	oddMem [`ICACHE_SETS];	// high half of each tile
	tileAddr	evenTag [`ICACHE_SETS];
	tileAddr	oddTag [`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0]	evenValid;
	logic [`ICACHE_SETS-1:0]	oddValid;

	tileAddr	nxtTileA;
	tileAddr	nxtTileB;
	setIndex	nxtSetA;
	setIndex	nxtSetB;
	setIndex	fillSet;

	tileAddr	lookTagA;
	tileAddr	lookTagB;
	logic		lookValidA;
	logic		lookValidB;

	// B is always the tile holding pc, A is the one after it when the window straddles
	always_comb
	begin
		nxtTileB = pc[31:4];
		if (pc[3])
			nxtTileA = nxtTileB + 28'd1;	// upper half comes from next tile
		else
			nxtTileA = nxtTileB;
	end

	assign nxtSetA = nxtTileA[`ICACHE_IX_BITS-1:0];
	assign nxtSetB = nxtTileB[`ICACHE_IX_BITS-1:0];
	assign fillSet = fillTile[`ICACHE_IX_BITS-1:0];

	always_ff @(posedge clock)
	begin
		lookPc		<= pc;
		reqTileA	<= nxtTileA;
		reqTileB	<= nxtTileB;
		bankDataA	<= evenMem[nxtSetA];	// even bank serves request A
		bankDataB	<= oddMem[nxtSetB];		// odd bank serves request B
		lookTagA	<= evenTag[nxtSetA];
		lookTagB	<= oddTag[nxtSetB];
		if (fillStrobe)
		begin
			evenMem[fillSet]	<= fillData[63:0];
			oddMem[fillSet]		<= fillData[127:64];
			evenTag[fillSet]	<= fillTile;
			oddTag[fillSet]		<= fillTile;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			evenValid	<= '0;
			oddValid	<= '0;
			lookValidA	<= 1'b0;
			lookValidB	<= 1'b0;
		end
		else
		begin
			lookValidA	<= evenValid[nxtSetA];
			lookValidB	<= oddValid[nxtSetB];
			if (fillStrobe)
			begin
				evenValid[fillSet]	<= 1'b1;
				oddValid[fillSet]	<= 1'b1;
			end
		end
	end

	assign missA = !lookValidA || (lookTagA != reqTileA);
	assign missB = !lookValidB || (lookTagB != reqTileB);

endmodule

//--- hdl/icachePkg.sv
package icachePkg;

	typedef logic [31:0]	pcAddr;		// byte address
	typedef logic [27:0]	tileAddr;	// address without low 4 bits
	typedef logic [3:0]		setIndex;	// same width as the set index define

	typedef logic [127:0]	tileData;	// whole tile, even half in the low bits
	typedef logic [63:0]	bankWord;	// one bank's half of a tile
	typedef logic [63:0]	fetchWindow;

	typedef logic [1:0]		memStatus;
	typedef logic [4:0]		memOpcode;
	typedef logic [1:0]		stepLen;	// in 16-bit units
	typedef logic [15:0]	fillCount;

	// miss handling FSM
	typedef enum logic [1:0]
	{
		missIdle,
		missRequest,
		missStore,
		missRelease
	} missState;

endpackage

//--- hdl/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry
`define ICACHE_SETS		16		// direct mapped, one tile per set
`define ICACHE_IX_BITS	4		// log2 of the set count

// status codes, shared by the memory port and the fetch port
`define MEM_OK_READY	2'b00	// idle, no transaction
`define MEM_OK_OK		2'b01	// data valid this cycle
`define MEM_OK_HOLD		2'b10	// busy, try again

// memory operation codes
`define MEM_OPM_READY	5'b00000	// no request
`define MEM_OPM_RD_TILE	5'b00111	// read one 128-bit tile

`endif

//--- hdl/instFetchCache.sv
`timescale 1ns/1ps

module instFetchCache
	import icachePkg::*;
(
	input	logic		clock,
	input	logic		reset,
	input	pcAddr		pc,
	output	fetchWindow	fetchWord,
	output	stepLen		fetchStep,
	output	memStatus	fetchStatus,
	output	pcAddr		memAddr,
	output	memOpcode	memOpm,
	input	tileData	memData,
	input	memStatus	memOk,
	output	fillCount	fills
);

	pcAddr		lookPc;
	bankWord	bankDataA;
	bankWord	bankDataB;
	tileAddr	reqTileA;
	tileAddr	reqTileB;
	logic		missA;
	logic		missB;
	logic		fillStrobe;
	tileAddr	fillTile;
	tileData	fillData;

	icacheBanks banks
	(
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.fillStrobe(fillStrobe),
		.fillTile(fillTile),
		.fillData(fillData),
		.lookPc(lookPc),
		.bankDataA(bankDataA),
		.bankDataB(bankDataB),
		.reqTileA(reqTileA),
		.reqTileB(reqTileB),
		.missA(missA),
		.missB(missB)
	);

	fetchAlign align
	(
		.lookPc(lookPc),
		.bankDataA(bankDataA),
		.bankDataB(bankDataB),
		.missA(missA),
		.missB(missB),
		.fetchWord(fetchWord),
		.fetchStep(fetchStep),
		.fetchStatus(fetchStatus)
	);

	missController misses
	(
		.clock(clock),
		.reset(reset),
		.missA(missA),
		.missB(missB),
		.reqTileA(reqTileA),
		.reqTileB(reqTileB),
		.memOk(memOk),
		.memData(memData),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.fillStrobe(fillStrobe),
		.fillTile(fillTile),
		.fillData(fillData)
	);

	fillCounter counter
	(
		.clock(clock),
		.reset(reset),
		.fillStrobe(fillStrobe),
		.fills(fills)
	);

endmodule

//--- hdl/missController.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module missController
	import icachePkg::*;
(
	input	logic		clock,
	input	logic		reset,
	input	logic		missA,
	input	logic		missB,
	input	tileAddr	reqTileA,
	input	tileAddr	reqTileB,
	input	memStatus	memOk,
	input	tileData	memData,
	output	pcAddr		memAddr,
	output	memOpcode	memOpm,
	output	logic		fillStrobe,
	output	tileAddr	fillTile,
	output	tileData	fillData
);

	missState	state;
	tileAddr	target;		// latched, pc may move during the fill
	tileData	captured;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= missIdle;
		end
		else
		begin
			case (state)
				missIdle:
				begin
					if ((missA || missB) && (memOk == `MEM_OK_READY))
						state <= missRequest;
				end
				missRequest:
				begin
					if (memOk == `MEM_OK_OK)
						state <= missStore;
				end
				missStore:
				begin
					state <= missRelease;	// one-cycle write pulse
				end
				missRelease:
				begin
					if (memOk == `MEM_OK_READY)
						state <= missIdle;
				end
				default:
				begin
					state <= missIdle;
				end
			endcase
		end
	end

	// fill target and captured tile
	always_ff @(posedge clock)
	begin
		if (state == missIdle)
		begin
			if (missB)
				target <= reqTileB;	// lower tile goes first
			else
				target <= reqTileA;
		end
		if ((state == missRequest) && (memOk == `MEM_OK_OK))
			captured <= memData;
	end

	// drop the request as soon as the data is taken
	always_comb
	begin
		if (state == missRequest)
			memOpm = `MEM_OPM_RD_TILE;
		else
			memOpm = `MEM_OPM_READY;
	end

	assign memAddr		= {target, 4'b0000};
	assign fillStrobe	= (state == missStore);
	assign fillTile		= target;
	assign fillData		= captured;

endmodule

//--- runSim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module instFetchBench -f compile.f \
	-Mdir obj_dir -o instFetchSim

./obj_dir/instFetchSim 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log
then
	echo "simulation failed"
	exit 1
fi

grep -q "Regression passed" sim.log
echo "simulation passed"
